/* include/mmio_macros.svh */
`ifndef MMIO_MACROS_SVH
`define MMIO_MACROS_SVH

// data and address width of the cpu side and the bus
`define MMIO_DW 32

// instruction space, fetches at or below this word go to the bus
`define MMIO_FETCH_MAX 1024

`define MMIO_REG_LO 1025  // external register file, read only
`define MMIO_REG_HI 1056

`define MMIO_DMEM_LO 1057 // data memory behind the bus
`define MMIO_DMEM_HI 1792

`define MMIO_TFT_LO 1793  // spi tft controller, write only
`define MMIO_TFT_HI 2047

`define MMIO_BUS_PREFIX 8'h33 // upper byte of every bus address

`endif

/* rtl/mmio_pkg.sv */
`default_nettype none

`include "mmio_macros.svh"

package mmio_pkg;

    // cpu memory handler operation, same codes as the cpu drives
    typedef enum logic [1:0] {
        MMIO_IDLE  = 2'b00,
        MMIO_WRITE = 2'b01,
        MMIO_READ  = 2'b10,
        MMIO_FETCH = 2'b11
    } mmio_op_e;

    // where the decoded access goes
    typedef enum logic [2:0] {
        TGT_NONE,      // no access in the request register
        TGT_BUS_FETCH, // instruction fetch over wishbone
        TGT_BUS_DATA,  // data read or write over wishbone
        TGT_REG,       // external register file read
        TGT_TFT,       // display write
        TGT_UNMAPPED   // completes at once with zero data
    } mmio_tgt_e;

    // access as held in the request stage
    typedef struct packed {
        mmio_op_e              op;
        logic [`MMIO_DW-1:0]   addr;
        logic [`MMIO_DW-1:0]   wdata;
        logic                  first;  // first cycle of a new access
    } mmio_req_t;

    // completion from one of the targets
    typedef struct packed {
        logic                  hit;    // access ends this cycle
        mmio_tgt_e             target;
        logic [`MMIO_DW-1:0]   rdata;
    } mmio_resp_t;

endpackage

`default_nettype wire

/* rtl/mmio_req_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mmio_macros.svh"

module mmio_req_stage
    import mmio_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  mmio_op_e            op_in,
    input  logic [`MMIO_DW-1:0] addr_in,
    input  logic [`MMIO_DW-1:0] wdata_in,
    output mmio_req_t           req
);

    mmio_op_e            op_q;
    logic                first_q;
    logic [`MMIO_DW-1:0] addr_q;   // payload, no reset
    logic [`MMIO_DW-1:0] wdata_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_q    <= MMIO_IDLE;
            first_q <= 1'b0;
        end else begin
            op_q    <= op_in;
            first_q <= (op_in != MMIO_IDLE) && (op_q == MMIO_IDLE); // idle to busy edge
        end
    end

    always_ff @(posedge clk) begin
        addr_q  <= addr_in;   // sampled every cycle, cpu holds it until done
        wdata_q <= wdata_in;
    end

    assign req = '{op: op_q, addr: addr_q, wdata: wdata_q, first: first_q};

    // the cpu must hold the access steady until it goes back to idle
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (op_q != MMIO_IDLE && op_in != MMIO_IDLE) |-> (op_in == op_q && addr_in == addr_q));

endmodule

`default_nettype wire

/* rtl/mmio_router.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mmio_macros.svh"

module mmio_router
    import mmio_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  mmio_req_t           req,
    output mmio_tgt_e           tgt,
    // external register file
    output logic                reg_rd,
    output logic [4:0]          reg_addr,
    input  logic [`MMIO_DW-1:0] reg_data,
    input  logic                reg_ack,
    input  logic                reg_cs,
    // spi tft controller
    output logic                tft_wr,
    output logic [`MMIO_DW-1:0] tft_addr,
    output logic [`MMIO_DW-1:0] tft_data,
    input  logic                tft_ack,
    output mmio_resp_t          resp
);

    logic in_reg;
    logic in_dmem;
    logic in_tft;
    logic pending;   // register or tft access in flight
    logic unm_q;     // unmapped access seen last cycle
    logic reg_hit;
    logic tft_hit;
    logic hit;

    // window decode on the registered address
    assign in_reg  = (req.addr >= `MMIO_REG_LO)  && (req.addr <= `MMIO_REG_HI);
    assign in_dmem = (req.addr >= `MMIO_DMEM_LO) && (req.addr <= `MMIO_DMEM_HI);
    assign in_tft  = (req.addr >= `MMIO_TFT_LO)  && (req.addr <= `MMIO_TFT_HI);

    always_comb begin
        tgt = TGT_UNMAPPED;  // anything not matched below
        case (req.op)
            MMIO_IDLE: tgt = TGT_NONE;
            MMIO_FETCH: begin
                if (req.addr <= `MMIO_FETCH_MAX) tgt = TGT_BUS_FETCH;
            end
            MMIO_READ: begin
                if (in_dmem) tgt = TGT_BUS_DATA;
                else if (in_reg) tgt = TGT_REG;
            end
            MMIO_WRITE: begin
                if (in_dmem) tgt = TGT_BUS_DATA;
                else if (in_tft) tgt = TGT_TFT;  // no register writes
            end
            default: tgt = TGT_UNMAPPED;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
            unm_q   <= 1'b0;
        end else begin
            unm_q <= req.first && (tgt == TGT_UNMAPPED); // done one cycle later
            if (req.first && (tgt == TGT_REG || tgt == TGT_TFT))
                pending <= 1'b1;
            else if (hit)
                pending <= 1'b0;
        end
    end

    // register read waits while chip select is low
    assign reg_rd   = pending && (tgt == TGT_REG) && reg_cs;
    assign reg_addr = req.addr[4:0];
    assign reg_hit  = reg_rd && reg_ack;

    assign tft_wr   = pending && (tgt == TGT_TFT); // held until ack
    assign tft_addr = req.addr;
    assign tft_data = req.wdata;
    assign tft_hit  = tft_wr && tft_ack;

    assign hit = reg_hit || tft_hit || unm_q;

    assign resp.hit    = hit;
    assign resp.target = tgt;
    assign resp.rdata  = reg_hit ? reg_data : '0;  // tft and unmapped give zero

    // one peripheral strobe at a time
    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(reg_rd && tft_wr));

endmodule

`default_nettype wire

/* rtl/wb_manager.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mmio_macros.svh"

module wb_manager
    import mmio_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  mmio_req_t           req,
    input  mmio_tgt_e           tgt,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output logic [`MMIO_DW-1:0] wb_adr,
    output logic [`MMIO_DW-1:0] wb_wdata,
    input  logic [`MMIO_DW-1:0] wb_rdata,
    input  logic                wb_ack,
    output mmio_resp_t          resp
);

    typedef enum logic {
        WB_IDLE,
        WB_ACTIVE
    } wb_state_e;

    wb_state_e state;
    logic      launch;

    assign launch = req.first && (tgt == TGT_BUS_FETCH || tgt == TGT_BUS_DATA);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WB_IDLE;
            wb_we <= 1'b0;
        end else begin
            case (state)
                WB_IDLE: if (launch) begin
                    state <= WB_ACTIVE;
                    wb_we <= (req.op == MMIO_WRITE); // fetch and read are bus reads
                end
                WB_ACTIVE: if (wb_ack) begin
                    state <= WB_IDLE;  // cyc and stb drop on the edge after ack
                    wb_we <= 1'b0;
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

    // address and data latched once per cycle, held until ack
    always_ff @(posedge clk) begin
        if (state == WB_IDLE && launch) begin
            wb_adr   <= {`MMIO_BUS_PREFIX, req.addr[23:0]};
            wb_wdata <= req.wdata;
        end
    end

    assign wb_cyc = (state == WB_ACTIVE);
    assign wb_stb = (state == WB_ACTIVE);  // classic cycle, stb follows cyc

    assign resp.hit    = wb_cyc && wb_ack;
    assign resp.target = tgt;
    assign resp.rdata  = wb_rdata;

    // classic wishbone holds the address through wait states
    a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (wb_adr == $past(wb_adr)));

endmodule

`default_nettype wire

/* rtl/mmio_resp_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mmio_macros.svh"

module mmio_resp_stage
    import mmio_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  mmio_req_t           req,
    input  mmio_tgt_e           tgt,
    input  mmio_resp_t          router_resp,
    input  mmio_resp_t          bus_resp,
    output logic                busy,
    output logic                done,
    output logic [`MMIO_DW-1:0] rdata_out,
    output logic [`MMIO_DW-1:0] instr_out
);

    mmio_resp_t sel;
    logic       hit;

    assign hit = router_resp.hit || bus_resp.hit;   // only one target per access
    assign sel = bus_resp.hit ? bus_resp : router_resp;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= hit;                  // one cycle pulse
            if (hit) busy <= 1'b0;
            else if (req.first) busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            if (sel.target == TGT_BUS_FETCH)
                instr_out <= sel.rdata;   // to the fetch unit
            else if (req.op == MMIO_READ && tgt != TGT_UNMAPPED)
                rdata_out <= sel.rdata;
            else
                rdata_out <= '0;          // writes and unmapped return zero
        end
    end

    // done ends an access, so busy was up the cycle before
    a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> $past(busy));

endmodule

`default_nettype wire

/* rtl/mmio_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mmio_macros.svh"

module mmio_subsystem
    import mmio_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    // cpu memory handler
    input  mmio_op_e            op_in,
    input  logic [`MMIO_DW-1:0] addr_in,
    input  logic [`MMIO_DW-1:0] wdata_in,
    output logic                busy,
    output logic                done,
    output logic [`MMIO_DW-1:0] rdata_out,
    output logic [`MMIO_DW-1:0] instr_out,
    // wishbone manager port
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output logic [`MMIO_DW-1:0] wb_adr,
    output logic [`MMIO_DW-1:0] wb_wdata,
    input  logic [`MMIO_DW-1:0] wb_rdata,
    input  logic                wb_ack,
    // external register file
    output logic                reg_rd,
    output logic [4:0]          reg_addr,
    input  logic [`MMIO_DW-1:0] reg_data,
    input  logic                reg_ack,
    input  logic                reg_cs,
    // spi tft
    output logic                tft_wr,
    output logic [`MMIO_DW-1:0] tft_addr,
    output logic [`MMIO_DW-1:0] tft_data,
    input  logic                tft_ack
);

    mmio_req_t  req;          // registered access
    mmio_tgt_e  tgt;          // decoded target
    mmio_resp_t router_resp;  // register, tft, unmapped completion
    mmio_resp_t bus_resp;     // wishbone completion

    mmio_req_stage u_req_stage (
        .clk, .rst_n, .op_in, .addr_in, .wdata_in, .req
    );

    mmio_router u_router (
        .clk, .rst_n, .req, .tgt,
        .reg_rd, .reg_addr, .reg_data, .reg_ack, .reg_cs,
        .tft_wr, .tft_addr, .tft_data, .tft_ack,
        .resp (router_resp)
    );

    wb_manager u_wb_manager (
        .clk, .rst_n, .req, .tgt,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack,
        .resp (bus_resp)
    );

    mmio_resp_stage u_resp_stage (
        .clk, .rst_n, .req, .tgt, .router_resp, .bus_resp,
        .busy, .done, .rdata_out, .instr_out
    );

endmodule

`default_nettype wire

/* bench/tb_mmio_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mmio_macros.svh"

module tb_mmio_subsystem
    import mmio_pkg::*;
();

    localparam int MAX_CYCLES = 200 * 12;  // 200 accesses, 12 cycles each

    logic        clk      = 1'b0;
    logic        rst_n    = 1'b0;
    mmio_op_e    op_in    = MMIO_IDLE;
    logic [31:0] addr_in  = '0;
    logic [31:0] wdata_in = '0;
    logic        busy;
    logic        done;
    logic [31:0] rdata_out;
    logic [31:0] instr_out;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_wdata;
    logic [31:0] wb_rdata = '0;
    logic        wb_ack   = 1'b0;
    logic        reg_rd;
    logic [4:0]  reg_addr;
    logic [31:0] reg_data;
    logic        reg_ack  = 1'b0;
    logic        reg_cs   = 1'b1;
    logic        tft_wr;
    logic [31:0] tft_addr;
    logic [31:0] tft_data;
    logic        tft_ack  = 1'b0;

    integer      seed     = 74;
    int          errors   = 0;
    int          checks   = 0;
    int          cycles   = 0;
    int          wb_wait  = -1;   // wait states left, -1 between bus cycles
    int          tft_wait = -1;
    int          cs_hold  = 0;    // further cycles of chip select low
    int          bus_acks = 0;
    int          lat;             // edges from request to done
    logic        done_cs;         // peripheral inputs of the cycle that ended in done
    logic        done_reg_ack;
    logic        done_tft_ack;
    logic [31:0] exp_adr;         // bus address and direction the current access expects
    logic        exp_we;
    logic [31:0] bus_mem [0:2047];
    logic [31:0] ref_mem [0:2047];  // reference copy, written by the stimulus only
    logic [31:0] tft_log_addr [$];
    logic [31:0] tft_log_data [$];

    mmio_subsystem u_mmio_subsystem (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] reg_value(input logic [4:0] a);
        return 32'hC5A0_0000 ^ ({27'b0, a} * 32'h0001_0203);  // distinct per register
    endfunction

    function automatic logic [31:0] fill_word(input int i);
        return i * 32'h9E37_79B1 + 32'h0BAD_F00D;
    endfunction

    function automatic logic [31:0] pick_addr(input int lo, input int hi);
        return lo + ({$random(seed)} % (hi - lo + 1));
    endfunction

    assign reg_data = reg_value(reg_addr);

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error t=%0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("t=%0t %s", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int n, input int errs_before);
        $display("test %-8s %0d accesses, %0d errors", name, n, errors - errs_before);
    endtask

    // one cpu access, held until done, then one idle cycle
    task automatic run_access(input mmio_op_e op, input logic [31:0] addr,
                              input logic [31:0] wdata);
        op_in    = op;      // taken on the next rising edge
        addr_in  = addr;
        wdata_in = wdata;
        exp_adr  = {8'h33, addr[23:0]};  // bus addresses carry 33 in the top byte
        exp_we   = (op == MMIO_WRITE);
        lat      = -1;
        do begin
            @(negedge clk);
            lat++;
            if (lat > 0)  // busy from the second edge on, low again with done
                check_value("busy", {31'b0, busy}, {31'b0, !done});
        end while (!done);
        done_cs      = reg_cs;   // model updates are still pending here
        done_reg_ack = reg_ack;
        done_tft_ack = tft_ack;
        check_true(!wb_cyc && !wb_stb, "bus cycle still open after done");
        op_in        = MMIO_IDLE;
        @(negedge clk);
        check_true(!done, "done stayed high for more than one cycle");
    endtask

    // wishbone memory, 0 to 3 wait states per cycle
    always @(negedge clk) begin
        if (wb_ack) begin
            wb_ack <= 1'b0;   // ack taken on the last edge
        end else if (wb_cyc && wb_stb) begin
            if (wb_wait < 0)
                wb_wait = $random(seed) & 3;
            if (wb_wait == 0) begin
                check_value("wb_adr", wb_adr, exp_adr);
                check_value("wb_we", {31'b0, wb_we}, {31'b0, exp_we});
                if (wb_we)
                    bus_mem[wb_adr[10:0]] = wb_wdata;
                else
                    wb_rdata <= bus_mem[wb_adr[10:0]];
                wb_ack <= 1'b1;
                bus_acks++;
                wb_wait = -1;
            end else begin
                wb_wait--;
            end
        end
    end

    // register file, chip select drops for short stretches
    always @(negedge clk) begin
        if (cs_hold > 0) begin
            cs_hold--;
            reg_cs <= 1'b0;
        end else if (($random(seed) & 3) == 0) begin
            cs_hold = $random(seed) & 3;  // low for 1 to 4 cycles
            reg_cs  <= 1'b0;
        end else begin
            reg_cs <= 1'b1;
        end
        reg_ack <= ($random(seed) & 1) != 0;  // only counts together with reg_rd
    end

    // tft controller logs each acknowledged write
    always @(negedge clk) begin
        if (tft_ack) begin
            tft_ack <= 1'b0;
        end else if (tft_wr) begin
            if (tft_wait < 0)
                tft_wait = $random(seed) & 3;
            if (tft_wait == 0) begin
                tft_ack <= 1'b1;
                tft_log_addr.push_back(tft_addr);
                tft_log_data.push_back(tft_data);
                tft_wait = -1;
            end else begin
                tft_wait--;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run still going after %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        int          e0;
        int          acks0;
        int          pick;
        logic [31:0] a;
        logic [31:0] d;
        for (int i = 0; i < 2048; i++) begin
            bus_mem[i] = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        e0 = errors;
        check_true(!busy && !done && !wb_cyc && !wb_stb && !reg_rd && !tft_wr,
                   "status or strobe high after reset");
        report_test("reset", 0, e0);

        e0 = errors;
        repeat (30) begin
            a = pick_addr(0, `MMIO_FETCH_MAX);
            run_access(MMIO_FETCH, a, 32'h0);
            check_value("instr_out", instr_out, ref_mem[a[10:0]]);
        end
        report_test("fetch", 30, e0);

        e0 = errors;
        repeat (30) begin
            a = pick_addr(`MMIO_DMEM_LO, `MMIO_DMEM_HI);
            d = $random(seed);
            ref_mem[a[10:0]] = d;
            run_access(MMIO_WRITE, a, d);
            check_value("rdata_out", rdata_out, 32'h0);  // writes give zero
            run_access(MMIO_READ, a, 32'h0);
            check_value("rdata_out", rdata_out, ref_mem[a[10:0]]);
        end
        report_test("data", 60, e0);

        e0 = errors;
        repeat (30) begin
            a = pick_addr(`MMIO_REG_LO, `MMIO_REG_HI);
            run_access(MMIO_READ, a, 32'h0);
            check_value("rdata_out", rdata_out, reg_value(a[4:0]));
            check_true(done_cs && done_reg_ack, "register read ended without chip select and ack");
        end
        report_test("register", 30, e0);

        e0 = errors;
        repeat (30) begin
            a = pick_addr(`MMIO_TFT_LO, `MMIO_TFT_HI);
            d = $random(seed);
            tft_log_addr.delete();
            tft_log_data.delete();
            run_access(MMIO_WRITE, a, d);
            check_true(done_tft_ack, "tft write ended without tft_ack");
            check_value("tft writes", tft_log_addr.size(), 1);
            if (tft_log_addr.size() == 1) begin
                check_value("tft_addr", tft_log_addr[0], a);
                check_value("tft_data", tft_log_data[0], d);
            end
        end
        report_test("tft", 30, e0);

        e0 = errors;
        repeat (20) begin
            pick  = $random(seed) & 3;
            // register read first so rdata_out holds a nonzero word
            run_access(MMIO_READ, pick_addr(`MMIO_REG_LO, `MMIO_REG_HI), 32'h0);
            acks0 = bus_acks;
            tft_log_addr.delete();
            case (pick)
                0: run_access(MMIO_FETCH, pick_addr(`MMIO_FETCH_MAX + 1, `MMIO_TFT_HI), 0);
                1: run_access(MMIO_WRITE, pick_addr(`MMIO_REG_LO, `MMIO_REG_HI), $random(seed));
                2: run_access(MMIO_READ, pick_addr(`MMIO_TFT_LO, `MMIO_TFT_HI), 0);
                default: run_access(MMIO_READ, pick_addr(`MMIO_TFT_HI + 1, 65535), 0);
            endcase
            check_value("done latency", lat, 2);
            check_value("rdata_out", rdata_out, 32'h0);
            check_true(bus_acks == acks0 && tft_log_addr.size() == 0,
                       "unmapped access reached the bus or the tft");
        end
        report_test("unmapped", 40, e0);

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
rtl/mmio_pkg.sv
rtl/mmio_req_stage.sv
rtl/mmio_router.sv
rtl/wb_manager.sv
rtl/mmio_resp_stage.sv
rtl/mmio_subsystem.sv
bench/tb_mmio_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mmio_subsystem
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: sim clean

# build, run, and decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx ">>> PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
